// ==== sim.f ====
+incdir+.
audio_pkg.sv
audio_regs.sv
audio_sample_fifo.sv
audio_pwm_output.sv
audio_top.sv
tb_clock_gen.sv
tb_audio.sv

// ==== tb_audio.sv ====
`include "audio_params.svh"

`timescale 1ns/10ps

module tb_audio;

	localparam int clock_period = 40;
	localparam int pwm_period = 1 << `AUDIO_PWM_BITS;
	localparam int fifo_depth = 1 << `AUDIO_FIFO_AW;
	localparam int ready_limit = 4;
	// two drains, four duty runs and the drain test come to about 45 periods
	localparam int test_periods = 45;
	localparam int watchdog_cycles = 2 * test_periods * pwm_period;

	logic clock;
	logic arst_n;
	logic request;
	logic rw;
	logic [3:0] address;
	audio_pkg::data_t wdata;
	audio_pkg::data_t rdata;
	logic ready;
	logic interrupt;
	logic pwm;

	tb_clock_gen #(.clock_period(clock_period), .reset_cycles(3)) clock_gen (
		.o_clock	(clock),
		.o_arst_n	(arst_n)
	);

	audio_top uut (
		.i_clock		(clock),
		.i_arst_n		(arst_n),
		.i_request		(request),
		.i_rw			(rw),
		.i_address		(address),
		.i_wdata		(wdata),
		.o_rdata		(rdata),
		.o_ready		(ready),
		.o_interrupt	(interrupt),
		.o_pwm			(pwm)
	);

	// ============================================================
	// reporting and bus access
	// ============================================================

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input audio_pkg::data_t actual, input audio_pkg::data_t expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			abort_run();
		end
	endtask

	// status word with level in 4:0 and full at 8, empty at 9 and overflow at 16
	function automatic audio_pkg::data_t expected_status(input int level, input logic full,
			input logic empty, input logic overflow);
		audio_pkg::data_t word;
		word = '0;
		word[4:0] = level[4:0];
		word[8] = full;
		word[9] = empty;
		word[16] = overflow;
		return word;
	endfunction

	task automatic bus_transfer(input logic write, input logic [1:0] offset,
			input audio_pkg::data_t data, output audio_pkg::data_t read_data, output int latency);
		@(negedge clock);
		request = 1'b1;
		rw = write;
		address = {offset, 2'b00};
		wdata = data;
		latency = 0;
		do begin
			@(negedge clock);
			latency++;
		end while (!ready && latency < ready_limit);
		if (!ready) begin
			$display("the DUT gave no ready within %0d cycles of a request", ready_limit);
			abort_run();
		end
		read_data = rdata;
		request = 1'b0;
		rw = 1'b0;
	endtask

	task automatic reg_write(input logic [1:0] offset, input audio_pkg::data_t data);
		audio_pkg::data_t unused;
		int latency;
		bus_transfer(1'b1, offset, data, unused, latency);
	endtask

	task automatic reg_read(input logic [1:0] offset, output audio_pkg::data_t data);
		int latency;
		bus_transfer(1'b0, offset, '0, data, latency);
	endtask

	// consumer pops one sample per period until the fifo is empty
	task automatic drain_fifo();
		audio_pkg::data_t status;
		int periods;
		reg_write(`AUDIO_REG_CONTROL, 32'h1);
		periods = 0;
		reg_read(`AUDIO_REG_SAMPLE, status);
		while (!status[9] && periods <= fifo_depth + 1) begin
			repeat (pwm_period) @(negedge clock);
			periods++;
			reg_read(`AUDIO_REG_SAMPLE, status);
		end
		if (!status[9]) begin
			$display("the sample FIFO did not drain with the output enabled");
			abort_run();
		end
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
	endtask

	// ============================================================
	// directed tests
	// ============================================================

	task automatic test_reset_state();
		audio_pkg::data_t status;
		int latency;
		check_value(ready, 0, "ready after reset");
		check_value(pwm, 0, "pwm after reset");
		check_value(interrupt, 0, "interrupt after reset");
		bus_transfer(1'b0, `AUDIO_REG_SAMPLE, '0, status, latency);
		check_value(latency, 1, "ready latency in cycles");
		check_value(status, expected_status(0, 1'b0, 1'b1, 1'b0), "status after reset");
	endtask

	task automatic test_register_readback();
		audio_pkg::data_t value;
		audio_pkg::data_t readback;
		int i;
		for (i = 0; i < 4; i++) begin
			value = $urandom;
			reg_write(`AUDIO_REG_CONTROL, value);
			reg_read(`AUDIO_REG_CONTROL, readback);
			check_value(readback, value & 32'h3, "control readback");
			value = $urandom;
			reg_write(`AUDIO_REG_THRESHOLD, value);
			reg_read(`AUDIO_REG_THRESHOLD, readback);
			check_value(readback, value & 32'h1f, "threshold readback");
		end
		reg_write(2'd3, $urandom);
		reg_read(2'd3, readback);
		check_value(readback, 0, "unused offset reads zero");
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		reg_write(`AUDIO_REG_THRESHOLD, 32'h0);
	endtask

	task automatic test_low_water_irq();
		int i;
		reg_write(`AUDIO_REG_THRESHOLD, 32'd4);
		reg_write(`AUDIO_REG_CONTROL, 32'h2);
		for (i = 0; i < 3; i++)
			reg_write(`AUDIO_REG_SAMPLE, $urandom);
		// push lands one edge after ready
		@(negedge clock);
		check_value(interrupt, 1, "interrupt with three samples queued");
		reg_write(`AUDIO_REG_SAMPLE, $urandom);
		@(negedge clock);
		check_value(interrupt, 0, "interrupt with four samples queued");
		reg_write(`AUDIO_REG_THRESHOLD, 32'd8);
		@(negedge clock);
		check_value(interrupt, 1, "interrupt with threshold raised to 8");
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		@(negedge clock);
		check_value(interrupt, 0, "interrupt with enable cleared");
		reg_write(`AUDIO_REG_THRESHOLD, 32'h0);
	endtask

	task automatic test_fill_overflow();
		audio_pkg::data_t status;
		int i;
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		for (i = 0; i < fifo_depth; i++)
			reg_write(`AUDIO_REG_SAMPLE, $urandom);
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(fifo_depth, 1'b1, 1'b0, 1'b0), "status when full");
		reg_write(`AUDIO_REG_SAMPLE, $urandom);
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(fifo_depth, 1'b1, 1'b0, 1'b1), "status after overflow");
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(fifo_depth, 1'b1, 1'b0, 1'b0), "overflow cleared");
		drain_fifo();
	endtask

	task automatic test_pwm_duty(input logic [7:0] duty);
		audio_pkg::data_t status;
		logic [7:0] low_byte;
		int high_cycles;
		low_byte = $urandom;
		reg_write(`AUDIO_REG_SAMPLE, {16'h0, duty, low_byte});
		reg_write(`AUDIO_REG_CONTROL, 32'h1);
		repeat (2 * pwm_period) @(negedge clock);
		high_cycles = 0;
		repeat (pwm_period) begin
			@(negedge clock);
			if (pwm)
				high_cycles++;
		end
		check_value(high_cycles, duty, $sformatf("pwm high cycles for duty %0d", duty));
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(0, 1'b0, 1'b1, 1'b0), "sample popped by pwm");
	endtask

	task automatic test_drain();
		audio_pkg::data_t status;
		audio_pkg::data_t sample;
		int i;
		int wait_cycles;
		for (i = 0; i < 5; i++) begin
			sample = $urandom;
			// last duty near full scale so the output is high at disable
			if (i == 4)
				sample[15:8] = 8'hff;
			reg_write(`AUDIO_REG_SAMPLE, sample);
		end
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(5, 1'b0, 1'b0, 1'b0), "five samples queued");
		reg_write(`AUDIO_REG_CONTROL, 32'h1);
		repeat (7 * pwm_period) @(negedge clock);
		reg_read(`AUDIO_REG_SAMPLE, status);
		check_value(status, expected_status(0, 1'b0, 1'b1, 1'b0), "status after drain");
		reg_write(`AUDIO_REG_CONTROL, 32'h0);
		wait_cycles = 0;
		while (pwm && wait_cycles < 2) begin
			@(negedge clock);
			wait_cycles++;
		end
		check_value(pwm, 0, "pwm low within two cycles of disable");
	endtask

	// ============================================================
	// sequence and watchdog
	// ============================================================

	initial begin
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		void'($urandom(23));
		wait (arst_n === 1'b1);
		@(negedge clock);
		test_reset_state();
		test_register_readback();
		test_low_water_irq();
		drain_fifo();
		test_fill_overflow();
		test_pwm_duty(8'd0);
		test_pwm_duty(8'd255);
		test_pwm_duty(8'($urandom_range(254, 1)));
		test_pwm_duty(8'($urandom_range(254, 1)));
		test_drain();
		$display("test passed");
		$finish;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
		abort_run();
	end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int clock_period = 40,
	parameter int reset_cycles = 3
) (
	output logic o_clock,
	output logic o_arst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(clock_period / 2) o_clock = ~o_clock;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		o_arst_n = 1'b0;
		repeat (reset_cycles) @(posedge o_clock);
		@(negedge o_clock);
		o_arst_n = 1'b1;
	end

endmodule

// ==== audio_top.sv ====
`timescale 1ns/10ps

module audio_top (
	input						i_clock,
	input						i_arst_n,

	input						i_request,
	input						i_rw,
	input			[3:0]		i_address,
	input	audio_pkg::data_t	i_wdata,
	output	audio_pkg::data_t	o_rdata,
	output						o_ready,

	output						o_interrupt,
	output						o_pwm
);

	// producer to buffer
	logic push;
	audio_pkg::sample_t push_data;
	logic clear_overflow;

	// buffer state
	audio_pkg::sample_t head;
	audio_pkg::level_t level;
	logic full;
	logic empty;
	logic overflow;

	// consumer
	logic pop;
	logic enable;

	// ============================================================
	// producer
	// ============================================================

	audio_regs regs (
		.i_clock			(i_clock),
		.i_arst_n			(i_arst_n),
		.i_request			(i_request),
		.i_rw				(i_rw),
		.i_address			(i_address),
		.i_wdata			(i_wdata),
		.o_rdata			(o_rdata),
		.o_ready			(o_ready),
		.o_push				(push),
		.o_push_data		(push_data),
		.o_clear_overflow	(clear_overflow),
		.i_level			(level),
		.i_full				(full),
		.i_empty			(empty),
		.i_overflow			(overflow),
		.o_enable			(enable),
		.o_interrupt		(o_interrupt)
	);

	// ============================================================
	// buffer
	// ============================================================

	audio_sample_fifo fifo (
		.i_clock			(i_clock),
		.i_arst_n			(i_arst_n),
		.i_push				(push),
		.i_push_data		(push_data),
		.i_pop				(pop),
		.i_clear_overflow	(clear_overflow),
		.o_head				(head),
		.o_level			(level),
		.o_full				(full),
		.o_empty			(empty),
		.o_overflow			(overflow)
	);

	// ============================================================
	// consumer
	// ============================================================

	audio_pwm_output pwm (
		.i_clock			(i_clock),
		.i_arst_n			(i_arst_n),
		.i_enable			(enable),
		.i_head				(head),
		.i_empty			(empty),
		.o_pop				(pop),
		.o_pwm				(o_pwm)
	);

endmodule

// ==== audio_pwm_output.sv ====
`include "audio_params.svh"

`timescale 1ns/10ps

module audio_pwm_output (
	input						i_clock,
	input						i_arst_n,

	input						i_enable,
	input	audio_pkg::sample_t	i_head,
	input						i_empty,

	output						o_pop,
	output	logic				o_pwm
);

	audio_pkg::pwm_state_t state;
	audio_pkg::duty_t count;
	audio_pkg::duty_t duty;
	audio_pkg::duty_t duty_next;

	logic period_start;

	// top bits of the sample set the duty
	assign period_start = (state == audio_pkg::RUNNING) && i_enable && (count == '0);
	assign o_pop = period_start && !i_empty;

	// empty fifo repeats the previous duty
	assign duty_next = o_pop ? i_head[$bits(audio_pkg::sample_t)-1 -: `AUDIO_PWM_BITS] : duty;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= audio_pkg::STOPPED;
			count <= '0;
			duty <= '0;
			o_pwm <= 1'b0;
		end else begin
			case (state)
				audio_pkg::STOPPED: begin
					count <= '0;
					o_pwm <= 1'b0;
					if (i_enable)
						state <= audio_pkg::RUNNING;
				end
				audio_pkg::RUNNING: begin
					if (!i_enable) begin
						state <= audio_pkg::STOPPED;
						count <= '0;
						o_pwm <= 1'b0;
					end else begin
						// wraps every 2**bits clocks
						count <= count + 1'b1;
						duty <= duty_next;
						o_pwm <= (count < duty_next);
					end
				end
			endcase
		end
	end

	a_pwm_low_stopped: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
			(state == audio_pkg::STOPPED) |-> !o_pwm
	);

endmodule

// ==== audio_sample_fifo.sv ====
`include "audio_params.svh"

`timescale 1ns/10ps

module audio_sample_fifo (
	input						i_clock,
	input						i_arst_n,

	input						i_push,
	input	audio_pkg::sample_t	i_push_data,
	input						i_pop,
	input						i_clear_overflow,

	output	audio_pkg::sample_t	o_head,
	output	audio_pkg::level_t	o_level,
	output						o_full,
	output						o_empty,
	output						o_overflow
);

	audio_pkg::sample_t mem [`AUDIO_FIFO_DEPTH];

	logic [`AUDIO_FIFO_AW-1:0] wr_ptr;
	logic [`AUDIO_FIFO_AW-1:0] rd_ptr;
	audio_pkg::level_t count;
	logic overflow;

	logic push_ok;
	logic pop_ok;

	// a push while full is dropped and nothing upstream waits
	assign push_ok = i_push && !o_full;
	assign pop_ok = i_pop && !o_empty;

	always_ff @(posedge i_clock) begin
		if (push_ok)
			mem[wr_ptr] <= i_push_data;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;

			// push and pop together leave the level alone
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// sticky until software writes control
			if (i_push && o_full)
				overflow <= 1'b1;
			else if (i_clear_overflow)
				overflow <= 1'b0;
		end
	end

	assign o_head = mem[rd_ptr];
	assign o_level = count;
	assign o_full = (count == `AUDIO_FIFO_DEPTH);
	assign o_empty = (count == '0);
	assign o_overflow = overflow;

	a_level_bound: assert property (
		@(posedge i_clock) disable iff (!i_arst_n) count <= `AUDIO_FIFO_DEPTH
	);

	// consumer must check empty before it pops
	a_no_pop_empty: assert property (
		@(posedge i_clock) disable iff (!i_arst_n) i_pop |-> !o_empty
	);

endmodule

// ==== audio_regs.sv ====
`include "audio_params.svh"

`timescale 1ns/10ps

module audio_regs (
	input						i_clock,
	input						i_arst_n,

	input						i_request,
	input						i_rw,
	input			[3:0]		i_address,
	input	audio_pkg::data_t	i_wdata,
	output	audio_pkg::data_t	o_rdata,
	output						o_ready,

	output						o_push,
	output	audio_pkg::sample_t	o_push_data,
	output						o_clear_overflow,

	input	audio_pkg::level_t	i_level,
	input						i_full,
	input						i_empty,
	input						i_overflow,

	output						o_enable,
	output						o_interrupt
);

	audio_pkg::regs_state_t state;

	// transfer captured when the request is first seen
	logic rw_q;
	audio_pkg::reg_addr_t addr_q;
	audio_pkg::data_t wdata_q;

	logic ctrl_enable;
	logic ctrl_irq_en;
	audio_pkg::level_t threshold;

	logic ack;
	logic wr_sample;
	logic wr_control;
	logic wr_threshold;
	audio_pkg::data_t status;

	// ============================================================
	// request / ready sequencing
	// ============================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= audio_pkg::IDLE;
		end else begin
			case (state)
				audio_pkg::IDLE: if (i_request) state <= audio_pkg::ACK;
				// held request is ignored here
				audio_pkg::ACK: state <= audio_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == audio_pkg::IDLE && i_request) begin
			rw_q <= i_rw;
			addr_q <= i_address[3:2];
			wdata_q <= i_wdata;
		end
	end

	assign ack = (state == audio_pkg::ACK);
	assign o_ready = ack;

	assign wr_sample = ack && rw_q && (addr_q == `AUDIO_REG_SAMPLE);
	assign wr_control = ack && rw_q && (addr_q == `AUDIO_REG_CONTROL);
	assign wr_threshold = ack && rw_q && (addr_q == `AUDIO_REG_THRESHOLD);

	// ============================================================
	// control and threshold
	// ============================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ctrl_enable <= 1'b0;
			ctrl_irq_en <= 1'b0;
			threshold <= '0;
		end else begin
			if (wr_control) begin
				ctrl_enable <= wdata_q[`AUDIO_CTRL_ENABLE];
				ctrl_irq_en <= wdata_q[`AUDIO_CTRL_IRQ_EN];
			end
			if (wr_threshold)
				threshold <= wdata_q[`AUDIO_FIFO_AW:0];
		end
	end

	// samples go straight to the fifo which drops them when full
	assign o_push = wr_sample;
	assign o_push_data = wdata_q[15:0];
	assign o_clear_overflow = wr_control;

	assign o_enable = ctrl_enable;

	// low water means software should refill
	assign o_interrupt = ctrl_irq_en && (i_level < threshold);

	// ============================================================
	// read data
	// ============================================================

	always_comb begin
		status = '0;
		status[`AUDIO_FIFO_AW:0] = i_level;
		status[`AUDIO_STAT_FULL] = i_full;
		status[`AUDIO_STAT_EMPTY] = i_empty;
		status[`AUDIO_STAT_OVERFLOW] = i_overflow;
	end

	always_comb begin
		o_rdata = '0;
		case (addr_q)
			`AUDIO_REG_SAMPLE: o_rdata = status;
			`AUDIO_REG_CONTROL: begin
				o_rdata[`AUDIO_CTRL_ENABLE] = ctrl_enable;
				o_rdata[`AUDIO_CTRL_IRQ_EN] = ctrl_irq_en;
			end
			`AUDIO_REG_THRESHOLD: o_rdata[`AUDIO_FIFO_AW:0] = threshold;
			default: o_rdata = '0;
		endcase
	end

	// each transfer gets exactly one ready pulse
	a_ready_single: assert property (
		@(posedge i_clock) disable iff (!i_arst_n) o_ready |=> !o_ready
	);

endmodule

// ==== audio_pkg.sv ====
`include "audio_params.svh"

package audio_pkg;

	// bus side
	typedef logic [31:0] data_t;
	typedef logic [1:0] reg_addr_t;

	// audio payload
	typedef logic [15:0] sample_t;

	// fill level with one extra bit so a full fifo fits
	typedef logic [`AUDIO_FIFO_AW:0] level_t;

	// pwm duty and period count
	typedef logic [`AUDIO_PWM_BITS-1:0] duty_t;

	typedef enum logic {
		IDLE,
		ACK
	} regs_state_t;

	typedef enum logic {
		STOPPED,
		RUNNING
	} pwm_state_t;

endpackage

// ==== audio_params.svh ====
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// ============================================================
// sample fifo geometry
// ============================================================

// 16 entries
`define AUDIO_FIFO_AW		4
`define AUDIO_FIFO_DEPTH	(1 << `AUDIO_FIFO_AW)

// ============================================================
// pwm output
// ============================================================

// one period is 2**bits clocks
`define AUDIO_PWM_BITS		8

// ============================================================
// register map word offsets
// ============================================================

`define AUDIO_REG_SAMPLE	2'd0
`define AUDIO_REG_CONTROL	2'd1
`define AUDIO_REG_THRESHOLD	2'd2

// control and status bit positions
`define AUDIO_CTRL_ENABLE	0
`define AUDIO_CTRL_IRQ_EN	1
`define AUDIO_STAT_FULL		8
`define AUDIO_STAT_EMPTY	9
`define AUDIO_STAT_OVERFLOW	16

`endif
